//--- adam.f
+incdir+rtl
rtl/adam_pkg.sv
rtl/adam_fifo.sv
rtl/adam_uart_tx.sv
rtl/adam_uart_rx.sv
rtl/adam_regs.sv
rtl/adam.sv
verification/adam_props.sv
verification/adam_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -f adam.f \
    --top-module adam_tb \
    --Mdir obj_dir \
    -o adam_sim

# Assertion errors are counted by the testbench, so the run goes on after one.
if ! ./obj_dir/adam_sim +verilator+error+limit+1000 > "$LOG" 2>&1; then
    echo "simulator exited with an error status"
fi
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG" || ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
echo "simulation passed"

//--- verification/adam_tb.sv
`include "adam_settings.svh"

module adam_tb;

    import adam_pkg::*;

    typedef enum int {
        OP_WRITE,
        OP_SEND_WAIT, // write, then let the frame reach the receive queue.
        OP_READ_RX,
        OP_READ_STATUS,
        OP_PAUSE_ON,
        OP_PAUSE_OFF,
        OP_BREAK,     // line held low for value cycles.
        OP_WAIT_RX,
        OP_SETTLE
    } op_t;

    localparam int BIT_CYCLES   = `ADAM_CLKS_PER_BIT;
    localparam int FRAME_CYCLES = 10 * `ADAM_CLKS_PER_BIT;

    logic                        clk;
    logic                        reset;
    logic                        bus_we;
    logic                        bus_re;
    reg_addr_t                   bus_addr;
    logic [`ADAM_DATA_WIDTH-1:0] bus_wdata;
    logic [`ADAM_DATA_WIDTH-1:0] bus_rdata;
    logic                        bus_rvalid;
    logic                        pause_req;
    logic                        pause_ack;
    logic                        uart_tx;
    logic                        uart_rx;
    logic                        brk;

    string                       row_name [$];
    op_t                         row_op [$];
    logic [`ADAM_DATA_WIDTH-1:0] row_value [$];
    logic [`ADAM_DATA_WIDTH-1:0] row_exp [$];

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          cycles = 0;
    int          cycle_limit = 1000000;

    assign uart_rx = brk ? 1'b0 : uart_tx; // loopback unless a break is forced.

    adam adam_inst (
        .clk        (clk),
        .reset      (reset),
        .bus_we     (bus_we),
        .bus_re     (bus_re),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_rdata  (bus_rdata),
        .bus_rvalid (bus_rvalid),
        .pause_req  (pause_req),
        .pause_ack  (pause_ack),
        .uart_tx    (uart_tx),
        .uart_rx    (uart_rx)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the tests did not end within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b[i]       = lfsr_state[0];
        end
    endtask

    task automatic add_row(input string name, input op_t op,
                           input logic [`ADAM_DATA_WIDTH-1:0] value,
                           input logic [`ADAM_DATA_WIDTH-1:0] exp);
        row_name.push_back(name);
        row_op.push_back(op);
        row_value.push_back(value);
        row_exp.push_back(exp);
    endtask

    task automatic check_value(input string name, input logic [`ADAM_DATA_WIDTH-1:0] exp,
                               input logic [`ADAM_DATA_WIDTH-1:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: expected 0x%08h, actual 0x%08h", name, exp, got);
        end
    endtask

    task automatic bus_write(input reg_addr_t addr, input logic [`ADAM_DATA_WIDTH-1:0] data);
        bus_we    = 1'b1;
        bus_addr  = addr;
        bus_wdata = data;
        @(posedge clk);
        #1;
        bus_we = 1'b0;
    endtask

    task automatic bus_read(input reg_addr_t addr, output logic [`ADAM_DATA_WIDTH-1:0] data);
        bus_re   = 1'b1;
        bus_addr = addr;
        @(posedge clk);
        #1;
        bus_re = 1'b0;
        checks++;
        if (!bus_rvalid) begin
            errors++;
            $display("read of register %s got no response in the next cycle", addr.name());
        end
        data = bus_rdata;
    endtask

    task automatic wait_rx();
        logic [`ADAM_DATA_WIDTH-1:0] st;
        do begin
            bus_read(REG_STATUS, st);
        end while (st[0]);
    endtask

    task automatic wait_frame();
        while (uart_tx) begin
            @(posedge clk);
            #1;
        end
        repeat (FRAME_CYCLES + 4) @(posedge clk); // entry is queued just after the stop bit.
        #1;
    endtask

    task automatic build_table();
        logic [7:0] fill [$];
        logic [7:0] b;
        add_row("status after reset", OP_READ_STATUS, 0, 32'h1);
        add_row("loop write a", OP_WRITE, 32'h41, 0);
        add_row("loop write b", OP_WRITE, 32'ha5, 0);
        add_row("loop write c", OP_WRITE, 32'h3c, 0);
        add_row("loop wait a", OP_WAIT_RX, 0, 0);
        add_row("loop read a", OP_READ_RX, 0, 32'h41);
        add_row("loop wait b", OP_WAIT_RX, 0, 0);
        add_row("loop read b", OP_READ_RX, 0, 32'ha5);
        add_row("loop wait c", OP_WAIT_RX, 0, 0);
        add_row("loop read c", OP_READ_RX, 0, 32'h3c);
        add_row("loop read empty", OP_READ_RX, 0, 0);
        add_row("status write", OP_WRITE, 32'h5a, 0);
        add_row("status wait", OP_WAIT_RX, 0, 0);
        add_row("status not empty", OP_READ_STATUS, 0, 32'h0);
        add_row("status read byte", OP_READ_RX, 0, 32'h5a);
        add_row("status empty again", OP_READ_STATUS, 0, 32'h1);
        add_row("pause ack", OP_PAUSE_ON, 0, 32'h1);
        for (int i = 0; i < `ADAM_TX_DEPTH + 2; i++) begin
            add_row($sformatf("pause write %0d", i), OP_WRITE, 32'h10 + i, 0);
        end
        add_row("pause tx full", OP_READ_STATUS, 0, 32'h3);
        add_row("pause release", OP_PAUSE_OFF, 0, 32'h0);
        for (int i = 0; i < `ADAM_TX_DEPTH; i++) begin
            add_row($sformatf("pause wait %0d", i), OP_WAIT_RX, 0, 0);
            add_row($sformatf("pause read %0d", i), OP_READ_RX, 0, 32'h10 + i);
        end
        add_row("pause settle", OP_SETTLE, 2 * FRAME_CYCLES, 0);
        add_row("pause dropped bytes", OP_READ_RX, 0, 0);
        add_row("break", OP_BREAK, 12 * BIT_CYCLES, 0);
        add_row("break wait", OP_WAIT_RX, 0, 0);
        add_row("break entry", OP_READ_RX, 0, 32'h100); // zero byte with framing error.
        add_row("break single entry", OP_READ_RX, 0, 0);
        for (int i = 0; i < `ADAM_RX_DEPTH + 2; i++) begin
            draw_byte(b);
            fill.push_back(b);
            add_row($sformatf("overrun send %0d", i), OP_SEND_WAIT, {24'd0, b}, 0);
        end
        add_row("overrun flag", OP_READ_STATUS, 0, 32'h4);
        for (int i = 0; i < `ADAM_RX_DEPTH; i++) begin
            add_row($sformatf("overrun read %0d", i), OP_READ_RX, 0, {24'd0, fill[i]});
        end
        add_row("overrun cleared", OP_READ_STATUS, 0, 32'h1);
    endtask

    initial begin
        logic [`ADAM_DATA_WIDTH-1:0] got;
        int                          bytes;
        clk        = 1'b0;
        reset      = 1'b1;
        bus_we     = 1'b0;
        bus_re     = 1'b0;
        bus_addr   = REG_TX_DATA;
        bus_wdata  = '0;
        pause_req  = 1'b0;
        brk        = 1'b0;
        errors     = 0;
        checks     = 0;
        lfsr_state = 32'hba7d_13c3;
        build_table();
        bytes = 0;
        foreach (row_op[i]) begin
            if (row_op[i] == OP_WRITE || row_op[i] == OP_SEND_WAIT || row_op[i] == OP_BREAK) begin
                bytes++;
            end
        end
        cycle_limit = (bytes * FRAME_CYCLES + row_op.size()) * 2;

        repeat (5) begin
            @(posedge clk);
            #1;
            check_value("uart_tx in reset", 32'h1, 32'(uart_tx));
            check_value("pause_ack in reset", 32'h0, 32'(pause_ack));
        end
        reset = 1'b0;
        @(posedge clk);
        #1;
        check_value("uart_tx after reset", 32'h1, 32'(uart_tx));
        check_value("pause_ack after reset", 32'h0, 32'(pause_ack));
        check_value("bus_rvalid after reset", 32'h0, 32'(bus_rvalid));

        for (int i = 0; i < row_op.size(); i++) begin
            case (row_op[i])
                OP_WRITE: bus_write(REG_TX_DATA, row_value[i]);
                OP_SEND_WAIT: begin
                    bus_write(REG_TX_DATA, row_value[i]);
                    wait_frame();
                end
                OP_READ_RX: begin
                    bus_read(REG_RX_DATA, got);
                    check_value(row_name[i], row_exp[i], got);
                end
                OP_READ_STATUS: begin
                    bus_read(REG_STATUS, got);
                    check_value(row_name[i], row_exp[i], got);
                end
                OP_PAUSE_ON: begin
                    pause_req = 1'b1;
                    // at most one frame in flight has to end first.
                    for (int n = 0; n <= FRAME_CYCLES && !pause_ack; n++) begin
                        @(posedge clk);
                        #1;
                    end
                    check_value(row_name[i], row_exp[i], 32'(pause_ack));
                end
                OP_PAUSE_OFF: begin
                    pause_req = 1'b0;
                    @(posedge clk);
                    #1;
                    check_value(row_name[i], row_exp[i], 32'(pause_ack));
                end
                OP_BREAK: begin
                    brk = 1'b1;
                    repeat (row_value[i]) @(posedge clk);
                    #1;
                    brk = 1'b0;
                end
                OP_WAIT_RX: wait_rx();
                OP_SETTLE: begin
                    repeat (row_value[i]) @(posedge clk);
                    #1;
                end
            endcase
        end

        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, adam_inst.adam_props_inst.fail_count);
        if (errors == 0 && adam_inst.adam_props_inst.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- verification/adam_props.sv
module adam_props (
    input logic clk,
    input logic reset,
    input logic bus_re,
    input logic bus_rvalid,
    input logic pause_req,
    input logic pause_ack,
    input logic uart_tx,
    input logic tx_pop,
    input logic tx_full
);

    int ack_fails    = 0;
    int rvalid_fails = 0;
    int idle_fails   = 0;
    int full_fails   = 0;
    int fail_count;

    assign fail_count = ack_fails + rvalid_fails + idle_fails + full_fails;

    ack_needs_req: assert property (
        @(posedge clk) disable iff (reset) $rose(pause_ack) |-> $past(pause_req)
    ) else begin
        $error("pause_ack rose without pause_req");
        ack_fails = ack_fails + 1;
    end

    rvalid_follows_re: assert property (
        @(posedge clk) disable iff (reset) bus_rvalid == $past(bus_re)
    ) else begin
        $error("bus_rvalid does not follow bus_re by one cycle");
        rvalid_fails = rvalid_fails + 1;
    end

    // the line rests while the port is paused.
    idle_while_paused: assert property (
        @(posedge clk) disable iff (reset) pause_ack |-> uart_tx
    ) else begin
        $error("uart_tx left idle while pause_ack was high");
        idle_fails = idle_fails + 1;
    end

    // only a pop takes a full transmit queue out of full.
    full_holds_without_pop: assert property (
        @(posedge clk) disable iff (reset) tx_full && !tx_pop |=> tx_full
    ) else begin
        $error("the transmit queue left full without a pop");
        full_fails = full_fails + 1;
    end

endmodule

bind adam adam_props adam_props_inst (
    .clk        (clk),
    .reset      (reset),
    .bus_re     (bus_re),
    .bus_rvalid (bus_rvalid),
    .pause_req  (pause_req),
    .pause_ack  (pause_ack),
    .uart_tx    (uart_tx),
    .tx_pop     (tx_pop),
    .tx_full    (tx_full)
);

//--- rtl/adam.sv
`include "adam_settings.svh"

module adam (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        bus_we,
    input  logic                        bus_re,
    input  adam_pkg::reg_addr_t         bus_addr,
    input  logic [`ADAM_DATA_WIDTH-1:0] bus_wdata,
    output logic [`ADAM_DATA_WIDTH-1:0] bus_rdata,
    output logic                        bus_rvalid,
    input  logic                        pause_req,
    output logic                        pause_ack,
    output logic                        uart_tx,
    input  logic                        uart_rx
);

    import adam_pkg::*;

    logic       tx_push;
    logic [7:0] tx_byte;
    logic       tx_full;
    logic       tx_empty;
    logic       tx_pop;
    logic [7:0] tx_head;

    logic       rx_valid;
    rx_entry_t  rx_entry;
    logic       rx_pop;
    rx_entry_t  rx_head;
    logic       rx_empty;
    logic       rx_full;
    logic       rx_drop;

    assign rx_drop = rx_valid && rx_full; // the new byte is lost.

    adam_regs regs (
        .clk        (clk),
        .reset      (reset),
        .bus_we     (bus_we),
        .bus_re     (bus_re),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_rdata  (bus_rdata),
        .bus_rvalid (bus_rvalid),
        .tx_push    (tx_push),
        .tx_byte    (tx_byte),
        .tx_full    (tx_full),
        .rx_pop     (rx_pop),
        .rx_head    (rx_head),
        .rx_empty   (rx_empty),
        .rx_drop    (rx_drop)
    );

    adam_fifo #(.T(logic [7:0]), .DEPTH(`ADAM_TX_DEPTH)) tx_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (tx_push),
        .push_data (tx_byte),
        .pop       (tx_pop),
        .pop_data  (tx_head),
        .empty     (tx_empty),
        .full      (tx_full)
    );

    adam_uart_tx #(.CLKS_PER_BIT(`ADAM_CLKS_PER_BIT)) serializer (
        .clk       (clk),
        .reset     (reset),
        .q_data    (tx_head),
        .q_empty   (tx_empty),
        .q_pop     (tx_pop),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .uart_tx   (uart_tx)
    );

    adam_uart_rx #(.CLKS_PER_BIT(`ADAM_CLKS_PER_BIT)) deserializer (
        .clk      (clk),
        .reset    (reset),
        .uart_rx  (uart_rx),
        .rx_valid (rx_valid),
        .rx_entry (rx_entry)
    );

    adam_fifo #(.T(rx_entry_t), .DEPTH(`ADAM_RX_DEPTH)) rx_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (rx_valid),
        .push_data (rx_entry),
        .pop       (rx_pop),
        .pop_data  (rx_head),
        .empty     (rx_empty),
        .full      (rx_full)
    );

endmodule

//--- rtl/adam_regs.sv
`include "adam_settings.svh"

module adam_regs (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         bus_we,
    input  logic                         bus_re,
    input  adam_pkg::reg_addr_t          bus_addr,
    input  logic [`ADAM_DATA_WIDTH-1:0]  bus_wdata,
    output logic [`ADAM_DATA_WIDTH-1:0]  bus_rdata,
    output logic                         bus_rvalid,
    output logic                         tx_push,
    output logic [7:0]                   tx_byte,
    input  logic                         tx_full,
    output logic                         rx_pop,
    input  adam_pkg::rx_entry_t          rx_head,
    input  logic                         rx_empty,
    input  logic                         rx_drop
);

    import adam_pkg::*;

    logic                        rx_overrun;
    logic                        status_rd;
    logic [`ADAM_DATA_WIDTH-1:0] rd_word;

    // writes to a full queue are dropped here.
    assign tx_push   = bus_we && (bus_addr == REG_TX_DATA) && !tx_full;
    assign tx_byte   = bus_wdata[7:0];
    assign rx_pop    = bus_re && (bus_addr == REG_RX_DATA) && !rx_empty;
    assign status_rd = bus_re && (bus_addr == REG_STATUS);

    always_comb begin
        rd_word = '0;
        case (bus_addr)
            REG_RX_DATA: begin
                if (!rx_empty) begin
                    rd_word[8:0] = rx_head; // empty queue reads zero.
                end
            end
            REG_STATUS: begin
                rd_word[2:0] = {rx_overrun, tx_full, rx_empty};
            end
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_rvalid <= 1'b0;
            rx_overrun <= 1'b0;
        end else begin
            bus_rvalid <= bus_re;
            // a drop in the same cycle as the status read is kept.
            if (rx_drop) begin
                rx_overrun <= 1'b1;
            end else if (status_rd) begin
                rx_overrun <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        bus_rdata <= bus_re ? rd_word : '0;
    end

endmodule

//--- rtl/adam_uart_rx.sv
module adam_uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                uart_rx,
    output logic                rx_valid,
    output adam_pkg::rx_entry_t rx_entry
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_WAIT_HIGH
    } rx_state_t;

    rx_state_t        state;
    logic [1:0]       sync;
    logic             rx_sync;
    logic             rx_prev;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shreg;
    logic             mid_start;
    logic             bit_done;

    assign rx_sync   = sync[1];
    assign mid_start = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign bit_done  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            sync    <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            sync    <= {sync[0], uart_rx};
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            clk_cnt  <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START; // falling edge.
                    end
                end
                RX_START: begin
                    if (mid_start) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // a high line at mid-bit was only a glitch.
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_done) begin
                        rx_valid <= 1'b1;
                        state    <= rx_sync ? RX_IDLE : RX_WAIT_HIGH;
                    end
                end
                default: begin
                    clk_cnt <= '0;
                    if (rx_sync) begin
                        state <= RX_IDLE; // break is over.
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_done) begin
            shreg <= {rx_sync, shreg[7:1]}; // lsb arrives first.
        end
        if (state == RX_STOP && bit_done) begin
            rx_entry.data      <= shreg;
            rx_entry.frame_err <= !rx_sync;
        end
    end

endmodule

//--- rtl/adam_uart_tx.sv
module adam_uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] q_data,
    input  logic       q_empty,
    output logic       q_pop,
    input  logic       pause_req,
    output logic       pause_ack,
    output logic       uart_tx
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shreg;
    logic             bit_done;

    // a new frame only starts from idle and never under pause.
    assign q_pop    = (state == TX_IDLE) && !q_empty && !pause_req;
    assign bit_done = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= TX_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            uart_tx   <= 1'b1; // line idles high.
            pause_ack <= 1'b0;
        end else begin
            pause_ack <= pause_req && (state == TX_IDLE);
            if (state == TX_IDLE) begin
                clk_cnt <= '0;
                if (q_pop) begin
                    state   <= TX_START;
                    uart_tx <= 1'b0; // start bit.
                end
            end else if (!bit_done) begin
                clk_cnt <= clk_cnt + 1'b1;
            end else begin
                clk_cnt <= '0;
                case (state)
                    TX_START: begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        uart_tx <= shreg[0]; // lsb first.
                    end
                    TX_DATA: begin
                        if (bit_idx == 3'd7) begin
                            state   <= TX_STOP;
                            uart_tx <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            uart_tx <= shreg[0];
                        end
                    end
                    default: state <= TX_IDLE; // end of stop bit.
                endcase
            end
        end
    end

    // payload shifter, loaded on the pop.
    always_ff @(posedge clk) begin
        if (q_pop) begin
            shreg <= q_data;
        end else if (bit_done && (state == TX_START || state == TX_DATA)) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

endmodule

//--- rtl/adam_fifo.sv
module adam_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic empty,
    output logic full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0; // wrap for any depth.
        end
        return ptr + 1'b1;
    endfunction

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign do_push  = push && !full; // push while full is ignored.
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];   // head entry, no read latency.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- rtl/adam_pkg.sv
package adam_pkg;

    // register map of the serial port.
    typedef enum logic [1:0] {
        REG_TX_DATA = 2'd0, // write only.
        REG_RX_DATA = 2'd1, // read pops the receive queue.
        REG_STATUS  = 2'd2  // read only.
    } reg_addr_t;

    // frame_err lands on bit 8 of the read word, data on bits 7 to 0.
    typedef struct packed {
        logic       frame_err;
        logic [7:0] data;
    } rx_entry_t;

endpackage

//--- rtl/adam_settings.svh
`ifndef ADAM_SETTINGS_SVH
`define ADAM_SETTINGS_SVH

// width of the register port data words.
`define ADAM_DATA_WIDTH 32

// clock cycles spent on each serial bit.
`define ADAM_CLKS_PER_BIT 8

`define ADAM_TX_DEPTH 4 // bytes waiting to be sent.
`define ADAM_RX_DEPTH 4 // entries waiting to be read.

`endif
